// ==== design/lq_pkg.sv ====
package lq_pkg;

    localparam int LQ_DEPTH          = 8;
    localparam int SQ_DEPTH          = 8;
    localparam int ISSUE_WAYS        = 2;
    localparam int ROB_DEPTH         = 32;
    localparam int PRF_DEPTH         = 64;
    localparam int BLOCK_OFFSET_BITS = 3;

    typedef logic [$clog2(LQ_DEPTH)-1:0]  lq_idx_t;
    typedef logic [LQ_DEPTH-1:0]          lq_mask_t;
    typedef logic [$clog2(SQ_DEPTH)-1:0]  sq_idx_t;
    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_idx_t;
    typedef logic [$clog2(PRF_DEPTH)-1:0] prf_idx_t;
    typedef logic [15:0]                  addr_t;
    typedef logic [31:0]                  data_t;
    // byte, half, word, double
    typedef logic [1:0]                   mem_size_t;

    typedef enum logic [2:0] {
        LQ_FREE,
        LQ_WAIT_ADDR,
        LQ_CHECK,
        LQ_READY,
        LQ_DONE
    } lq_state_t;

    typedef struct packed {
        rob_idx_t  rob_idx;
        prf_idx_t  prf_idx;
        mem_size_t size;
        // store queue tail seen at issue, marks the older stores
        sq_idx_t   sq_tail;
    } load_issue_t;

    typedef struct packed {
        logic     valid;
        logic     is_ls;
        rob_idx_t rob_idx;
        addr_t    addr;
    } alu_result_t;

    typedef struct packed {
        logic      addr_valid;
        logic      data_valid;
        addr_t     addr;
        mem_size_t size;
        data_t     data;
    } sq_entry_t;

    typedef struct packed {
        lq_state_t state;
        rob_idx_t  rob_idx;
        prf_idx_t  prf_idx;
        mem_size_t size;
        addr_t     addr;
        sq_idx_t   sq_tail;
        data_t     data;
    } lq_entry_t;

    typedef struct packed {
        addr_t     addr;
        mem_size_t size;
    } dcache_req_t;

    typedef struct packed {
        logic     valid;
        data_t    data;
        prf_idx_t prf_idx;
        rob_idx_t rob_idx;
    } cdb_t;

endpackage

// ==== design/lq_alloc.sv ====
`timescale 1ns/10ps

module lq_alloc import lq_pkg::*; (
    input  lq_mask_t                free_mask,
    input  logic [ISSUE_WAYS-1:0]   ld_en,
    output lq_mask_t                alloc_grant [ISSUE_WAYS]
);

    lq_mask_t low_pick;
    lq_mask_t high_pick;
    lq_mask_t rest_mask;

    always_comb begin
        low_pick = '0;
        // walk downward so the lowest free entry wins
        for (int i = LQ_DEPTH - 1; i >= 0; i--) begin
            if (free_mask[i]) begin
                low_pick = lq_mask_t'(1) << i;
            end
        end
        alloc_grant[0] = ld_en[0] ? low_pick : '0;

        // way 1 takes from the top, skipping way 0's entry
        rest_mask = free_mask & ~alloc_grant[0];
        high_pick = '0;
        for (int i = 0; i < LQ_DEPTH; i++) begin
            if (rest_mask[i]) begin
                high_pick = lq_mask_t'(1) << i;
            end
        end
        alloc_grant[1] = ld_en[1] ? high_pick : '0;
    end

endmodule

// ==== design/lq_rr_arbiter.sv ====
`timescale 1ns/10ps

module lq_rr_arbiter import lq_pkg::*; (
    input  logic     clock,
    input  logic     rst,
    input  lq_mask_t req,
    output lq_mask_t gnt
);

    lq_idx_t last;
    lq_idx_t gnt_idx;
    logic    found;

    always_comb begin
        lq_idx_t idx;
        gnt     = '0;
        gnt_idx = last;
        found   = 1'b0;
        // search starts one past the previous winner, wraps back to it
        for (int k = 1; k <= LQ_DEPTH; k++) begin
            idx = last + lq_idx_t'(k);
            if (!found && req[idx]) begin
                found   = 1'b1;
                gnt_idx = idx;
            end
        end
        if (found) begin
            gnt[gnt_idx] = 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            last <= lq_idx_t'(LQ_DEPTH - 1);
        end else if (found) begin
            last <= gnt_idx;
        end
    end

    assert property (@(posedge clock) disable iff (rst)
        $onehot0(gnt) && ((gnt & ~req) == '0))
        else $error("arbiter grant not one-hot or not requested");

endmodule

// ==== design/lq_store_check.sv ====
`timescale 1ns/10ps

module lq_store_check import lq_pkg::*; (
    input  lq_entry_t entries [LQ_DEPTH],
    input  sq_entry_t sq [SQ_DEPTH],
    input  sq_idx_t   sq_head,
    output lq_mask_t  fwd_mask,
    output data_t     fwd_data [LQ_DEPTH],
    output lq_mask_t  clear_mask,
    output lq_mask_t  hold_mask
);

    for (genvar i = 0; i < LQ_DEPTH; i++) begin : g_load
        logic  fwd;
        logic  clear;
        logic  hold;
        data_t fwd_word;

        always_comb begin
            logic [SQ_DEPTH-1:0] age_mask;
            logic                in_range;
            logic                unresolved;
            logic                found;
            logic                match;
            logic                is_check;
            sq_idx_t             j;
            sq_idx_t             sel;

            // stores from head up to the load's tail are older than the load
            age_mask = '0;
            in_range = 1'b1;
            for (int k = 0; k < SQ_DEPTH; k++) begin
                j = sq_head + sq_idx_t'(k);
                if (j == entries[i].sq_tail) begin
                    in_range = 1'b0;
                end
                age_mask[j] = in_range;
            end

            // oldest to youngest, so the last block hit is the youngest
            unresolved = 1'b0;
            found      = 1'b0;
            sel        = sq_head;
            for (int k = 0; k < SQ_DEPTH; k++) begin
                j = sq_head + sq_idx_t'(k);
                if (age_mask[j]) begin
                    if (!sq[j].addr_valid) begin
                        unresolved = 1'b1;
                    end else if (sq[j].addr[$bits(addr_t)-1:BLOCK_OFFSET_BITS] ==
                                 entries[i].addr[$bits(addr_t)-1:BLOCK_OFFSET_BITS]) begin
                        found = 1'b1;
                        sel   = j;
                    end
                end
            end

            match = sq[sel].addr[BLOCK_OFFSET_BITS-1:0] ==
                    entries[i].addr[BLOCK_OFFSET_BITS-1:0]
                    && sq[sel].size == entries[i].size
                    && sq[sel].data_valid;

            is_check = entries[i].state == LQ_CHECK;
            fwd      = is_check && !unresolved && found && match;
            clear    = is_check && !unresolved && !found;
            // partial overlap or unknown store address
            hold     = is_check && (unresolved || (found && !match));
            fwd_word = sq[sel].data;
        end

        assign fwd_mask[i]   = fwd;
        assign clear_mask[i] = clear;
        assign hold_mask[i]  = hold;
        assign fwd_data[i]   = fwd_word;
    end

endmodule

// ==== design/lq_entries.sv ====
`timescale 1ns/10ps

module lq_entries import lq_pkg::*; (
    input  logic        clock,
    input  logic        rst,
    input  logic        except,
    input  lq_mask_t    alloc_grant [ISSUE_WAYS],
    input  load_issue_t ld_issue [ISSUE_WAYS],
    input  alu_result_t alu [ISSUE_WAYS],
    input  lq_mask_t    fwd_mask,
    input  data_t       fwd_data [LQ_DEPTH],
    input  lq_mask_t    clear_mask,
    input  lq_mask_t    hold_mask,
    input  lq_mask_t    cache_gnt,
    input  lq_mask_t    cdb_gnt,
    input  logic        dc_hit,
    input  data_t       dc_data,
    output lq_entry_t   entries [LQ_DEPTH],
    output lq_mask_t    free_mask,
    output lq_mask_t    ready_mask,
    output lq_mask_t    done_mask,
    output logic        rd_en,
    output dcache_req_t rd_req,
    output cdb_t        cdb
);

    lq_mask_t alu_hit [ISSUE_WAYS];

    for (genvar w = 0; w < ISSUE_WAYS; w++) begin : g_way
        for (genvar i = 0; i < LQ_DEPTH; i++) begin : g_hit
            assign alu_hit[w][i] = alu[w].valid && alu[w].is_ls
                && entries[i].state == LQ_WAIT_ADDR
                && alu[w].rob_idx == entries[i].rob_idx;
        end

        // a ROB index names at most one waiting load
        assert property (@(posedge clock) disable iff (rst) $onehot0(alu_hit[w]))
            else $error("ALU result on way %0d captured by several entries", w);
    end

    for (genvar i = 0; i < LQ_DEPTH; i++) begin : g_entry
        lq_entry_t entry_q;
        lq_entry_t entry_d;

        always_comb begin
            entry_d = entry_q;
            case (entry_q.state)
                LQ_FREE: begin
                    for (int w = 0; w < ISSUE_WAYS; w++) begin
                        if (alloc_grant[w][i]) begin
                            entry_d.state   = LQ_WAIT_ADDR;
                            entry_d.rob_idx = ld_issue[w].rob_idx;
                            entry_d.prf_idx = ld_issue[w].prf_idx;
                            entry_d.size    = ld_issue[w].size;
                            entry_d.sq_tail = ld_issue[w].sq_tail;
                        end
                    end
                end
                LQ_WAIT_ADDR: begin
                    for (int w = 0; w < ISSUE_WAYS; w++) begin
                        if (alu_hit[w][i]) begin
                            entry_d.state = LQ_CHECK;
                            entry_d.addr  = alu[w].addr;
                        end
                    end
                end
                LQ_CHECK: begin
                    if (fwd_mask[i]) begin
                        entry_d.state = LQ_DONE;
                        entry_d.data  = fwd_data[i];
                    end else if (clear_mask[i]) begin
                        entry_d.state = LQ_READY;
                    end
                end
                // a miss leaves the entry here to compete again
                LQ_READY: begin
                    if (cache_gnt[i] && dc_hit) begin
                        entry_d.state = LQ_DONE;
                        entry_d.data  = dc_data;
                    end
                end
                LQ_DONE: begin
                    if (cdb_gnt[i]) begin
                        entry_d.state = LQ_FREE;
                    end
                end
                default: entry_d.state = LQ_FREE;
            endcase
        end

        always_ff @(posedge clock) begin
            if (rst || except) begin
                entry_q.state <= LQ_FREE;
            end else begin
                entry_q <= entry_d;
            end
        end

        assign entries[i]    = entry_q;
        assign free_mask[i]  = entry_q.state == LQ_FREE;
        assign ready_mask[i] = entry_q.state == LQ_READY;
        assign done_mask[i]  = entry_q.state == LQ_DONE;

        // store check returns exactly one verdict, and only for checking loads
        assert property (@(posedge clock) disable iff (rst)
            (entry_q.state == LQ_CHECK) == $onehot({fwd_mask[i], clear_mask[i], hold_mask[i]}))
            else $error("store check verdict mismatch on entry %0d", i);
    end

    // grants are one-hot, so OR-ing the selected fields is a mux
    always_comb begin
        rd_req = '0;
        cdb    = '0;
        for (int i = 0; i < LQ_DEPTH; i++) begin
            if (cache_gnt[i]) begin
                rd_req.addr = entries[i].addr;
                rd_req.size = entries[i].size;
            end
            if (cdb_gnt[i]) begin
                cdb.data    = entries[i].data;
                cdb.prf_idx = entries[i].prf_idx;
                cdb.rob_idx = entries[i].rob_idx;
            end
        end
        // nothing from a flushed queue reaches the CDB
        cdb.valid = (|cdb_gnt) && !except;
    end

    assign rd_en = |cache_gnt;

endmodule

// ==== design/load_queue.sv ====
`timescale 1ns/10ps

module load_queue import lq_pkg::*; (
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  except,
    input  logic [ISSUE_WAYS-1:0] ld_en,
    input  load_issue_t           ld_issue [ISSUE_WAYS],
    input  alu_result_t           alu [ISSUE_WAYS],
    input  sq_entry_t             sq [SQ_DEPTH],
    input  sq_idx_t               sq_head,
    input  logic                  dc_hit,
    input  data_t                 dc_data,
    output logic                  rd_en,
    output dcache_req_t           rd_req,
    output cdb_t                  cdb
);

    lq_mask_t  free_mask;
    lq_mask_t  alloc_grant [ISSUE_WAYS];
    lq_entry_t entries [LQ_DEPTH];
    lq_mask_t  fwd_mask;
    data_t     fwd_data [LQ_DEPTH];
    lq_mask_t  clear_mask;
    lq_mask_t  hold_mask;
    lq_mask_t  ready_mask;
    lq_mask_t  done_mask;
    lq_mask_t  cache_gnt;
    lq_mask_t  cdb_gnt;

    lq_alloc alloc (
        .free_mask   (free_mask),
        .ld_en       (ld_en),
        .alloc_grant (alloc_grant)
    );

    // the issuer never spends more credits than there are free entries
    for (genvar w = 0; w < ISSUE_WAYS; w++) begin : g_credit
        assert property (@(posedge clock) disable iff (rst)
            ld_en[w] |-> $onehot(alloc_grant[w]))
            else $error("load issued on way %0d without a free entry", w);
    end

    lq_entries entry_array (
        .clock       (clock),
        .rst         (rst),
        .except      (except),
        .alloc_grant (alloc_grant),
        .ld_issue    (ld_issue),
        .alu         (alu),
        .fwd_mask    (fwd_mask),
        .fwd_data    (fwd_data),
        .clear_mask  (clear_mask),
        .hold_mask   (hold_mask),
        .cache_gnt   (cache_gnt),
        .cdb_gnt     (cdb_gnt),
        .dc_hit      (dc_hit),
        .dc_data     (dc_data),
        .entries     (entries),
        .free_mask   (free_mask),
        .ready_mask  (ready_mask),
        .done_mask   (done_mask),
        .rd_en       (rd_en),
        .rd_req      (rd_req),
        .cdb         (cdb)
    );

    lq_store_check store_check (
        .entries    (entries),
        .sq         (sq),
        .sq_head    (sq_head),
        .fwd_mask   (fwd_mask),
        .fwd_data   (fwd_data),
        .clear_mask (clear_mask),
        .hold_mask  (hold_mask)
    );

    // one load per cycle to the data cache
    lq_rr_arbiter cache_arb (
        .clock (clock),
        .rst   (rst),
        .req   (ready_mask),
        .gnt   (cache_gnt)
    );

    // one broadcast per cycle, never stalled
    lq_rr_arbiter cdb_arb (
        .clock (clock),
        .rst   (rst),
        .req   (done_mask),
        .gnt   (cdb_gnt)
    );

endmodule

// ==== sim/load_queue_tb.sv ====
`timescale 1ns/10ps

module load_queue_tb import lq_pkg::*; ();

    localparam int        CLK_PERIOD      = 8;
    localparam int        DRIVE_DELAY     = 1;
    localparam int        RESET_CYCLES    = 5;
    localparam int        NUM_TESTS       = 5;
    localparam int        CYCLES_PER_TEST = 200;
    localparam int        WAIT_LIMIT      = 100;
    localparam mem_size_t SIZE_WORD       = 2'd2;

    logic                  clock;
    logic                  rst;
    logic                  except;
    logic [ISSUE_WAYS-1:0] ld_en;
    load_issue_t           ld_issue [ISSUE_WAYS];
    alu_result_t           alu [ISSUE_WAYS];
    sq_entry_t             sq [SQ_DEPTH];
    sq_idx_t               sq_head;
    logic                  dc_hit;
    data_t                 dc_data;
    logic                  rd_en;
    dcache_req_t           rd_req;
    cdb_t                  cdb;

    // issue side credit model, credits = depth - (issued - returned)
    int                    issued;
    int                    returned;
    int                    miss_target;
    int                    misses_done;
    cdb_t                  cdb_log [$];
    dcache_req_t           rd_log [$];
    logic [ROB_DEPTH-1:0]  flushed;
    addr_t                 exp_addr [ROB_DEPTH];
    prf_idx_t              exp_prf [ROB_DEPTH];

    load_queue UUT (
        .clock    (clock),
        .rst      (rst),
        .except   (except),
        .ld_en    (ld_en),
        .ld_issue (ld_issue),
        .alu      (alu),
        .sq       (sq),
        .sq_head  (sq_head),
        .dc_hit   (dc_hit),
        .dc_data  (dc_data),
        .rd_en    (rd_en),
        .rd_req   (rd_req),
        .cdb      (cdb)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    function automatic data_t cache_word(input addr_t a);
        return {a ^ 16'hc35a, ~a};
    endfunction

    // cache model answers in the same cycle, misses until the target count is reached
    assign dc_hit  = misses_done >= miss_target;
    assign dc_data = cache_word(rd_req.addr);

    always @(posedge clock) begin
        if (rst) begin
            misses_done <= 0;
        end else if (rd_en && !dc_hit) begin
            misses_done <= misses_done + 1;
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "stopping at first error");
    endtask

    // outputs are stable at the falling edge
    always @(negedge clock) begin
        if (!rst && cdb.valid) begin
            if (flushed[cdb.rob_idx]) begin
                fail_run($sformatf("flushed load with rob %0d was broadcast at %0t",
                                   cdb.rob_idx, $time));
            end
            cdb_log.push_back(cdb);
            returned++;
        end
        if (!rst && rd_en) begin
            rd_log.push_back(rd_req);
        end
    end

    function automatic int credits_left();
        return LQ_DEPTH - (issued - returned);
    endfunction

    function automatic cdb_t cache_result(input rob_idx_t r);
        cdb_t e;
        e.valid   = 1'b1;
        e.data    = cache_word(exp_addr[r]);
        e.prf_idx = exp_prf[r];
        e.rob_idx = r;
        return e;
    endfunction

    task automatic compare_cdb(input string name, input cdb_t got, input cdb_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic compare_rd_req(input string name, input dcache_req_t got,
                                  input dcache_req_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        if (got != exp) begin
            fail_run($sformatf("Mismatch at %0t: %s got %0d expected %0d",
                               $time, name, got, exp));
        end
    endtask

    // all driving tasks start and end 1 ns after a rising edge
    task automatic issue_loads(input int count, input rob_idx_t rob0, input sq_idx_t tail);
        rob_idx_t r;
        if (credits_left() < count) begin
            fail_run("load issued with no credits left");
        end
        for (int w = 0; w < count; w++) begin
            r = rob0 + rob_idx_t'(w);
            exp_prf[r]          = prf_idx_t'($urandom);
            flushed[r]          = 1'b0;
            ld_issue[w].rob_idx = r;
            ld_issue[w].prf_idx = exp_prf[r];
            ld_issue[w].size    = SIZE_WORD;
            ld_issue[w].sq_tail = tail;
            ld_en[w]            = 1'b1;
        end
        issued = issued + count;
        @(posedge clock);
        #DRIVE_DELAY;
        ld_en = '0;
    endtask

    task automatic send_addr(input rob_idx_t r, input addr_t a);
        exp_addr[r]    = a;
        alu[0].valid   = 1'b1;
        alu[0].is_ls   = 1'b1;
        alu[0].rob_idx = r;
        alu[0].addr    = a;
        @(posedge clock);
        #DRIVE_DELAY;
        alu[0].valid = 1'b0;
    endtask

    task automatic flush_queue();
        except = 1'b1;
        @(posedge clock);
        #DRIVE_DELAY;
        except = 1'b0;
        // issuer takes all credits back itself
        issued = returned;
    endtask

    task automatic clear_store_queue();
        foreach (sq[k]) begin
            sq[k] = '0;
        end
        sq_head = '0;
    endtask

    task automatic wait_cdb(input int mark, input int beats);
        int cycles;
        cycles = 0;
        while (cdb_log.size() < mark + beats) begin
            if (cycles == WAIT_LIMIT) begin
                fail_run($sformatf("no CDB broadcast within %0d cycles at %0t",
                                   WAIT_LIMIT, $time));
            end else begin
                @(posedge clock);
                #DRIVE_DELAY;
                cycles++;
            end
        end
    endtask

    task automatic expect_silent(input int cycles);
        repeat (cycles) begin
            @(negedge clock);
            if (rd_en || cdb.valid) begin
                fail_run($sformatf("unexpected activity at %0t: rd_en %b cdb.valid %b",
                                   $time, rd_en, cdb.valid));
            end
        end
        @(posedge clock);
        #DRIVE_DELAY;
    endtask

    task automatic test_reset_and_flush();
        rob_idx_t r;
        r = rob_idx_t'($urandom);
        expect_silent(10);
        issue_loads(2, r, sq_head);
        send_addr(r, addr_t'($urandom));
        flushed[r]                  = 1'b1;
        flushed[r + rob_idx_t'(1)] = 1'b1;
        flush_queue();
        expect_silent(10);
    endtask

    task automatic test_forwarding();
        rob_idx_t r;
        addr_t    a;
        data_t    d;
        cdb_t     exp;
        int       cdb_mark;
        int       rd_mark;
        r        = rob_idx_t'($urandom);
        a        = addr_t'($urandom);
        d        = data_t'($urandom);
        cdb_mark = cdb_log.size();
        rd_mark  = rd_log.size();
        sq_head  = '0;
        sq[0]    = '{1'b1, 1'b1, a, SIZE_WORD, d};
        issue_loads(1, r, sq_idx_t'(1));
        send_addr(r, a);
        wait_cdb(cdb_mark, 1);
        exp = '{1'b1, d, exp_prf[r], r};
        compare_cdb("cdb", cdb_log[cdb_mark], exp);
        compare_count("rd_en beats for forwarded load", rd_log.size() - rd_mark, 0);
        clear_store_queue();
    endtask

    task automatic test_cache_miss();
        rob_idx_t    r;
        addr_t       a;
        dcache_req_t exp_req;
        int          cdb_mark;
        int          rd_mark;
        r           = rob_idx_t'($urandom);
        a           = addr_t'($urandom);
        cdb_mark    = cdb_log.size();
        rd_mark     = rd_log.size();
        miss_target = misses_done + 2;
        issue_loads(1, r, sq_head);
        send_addr(r, a);
        wait_cdb(cdb_mark, 1);
        // two misses then the hit
        compare_count("rd_en beats", rd_log.size() - rd_mark, 3);
        exp_req = '{a, SIZE_WORD};
        for (int k = rd_mark; k < rd_log.size(); k++) begin
            compare_rd_req("rd_req", rd_log[k], exp_req);
        end
        compare_cdb("cdb", cdb_log[cdb_mark], cache_result(r));
    endtask

    task automatic test_store_wait();
        rob_idx_t    r;
        addr_t       a;
        dcache_req_t exp_req;
        int          cdb_mark;
        int          rd_mark;
        // older store with unknown address
        r        = rob_idx_t'($urandom);
        a        = addr_t'($urandom);
        cdb_mark = cdb_log.size();
        rd_mark  = rd_log.size();
        sq_head  = sq_idx_t'(2);
        issue_loads(1, r, sq_idx_t'(3));
        send_addr(r, a);
        expect_silent(10);
        sq[2] = '{1'b1, 1'b0, a ^ 16'h0100, SIZE_WORD, '0};
        wait_cdb(cdb_mark, 1);
        exp_req = '{a, SIZE_WORD};
        compare_rd_req("rd_req", rd_log[rd_mark], exp_req);
        compare_cdb("cdb", cdb_log[cdb_mark], cache_result(r));

        // same block, other offset
        r        = r + rob_idx_t'(5);
        a        = addr_t'($urandom);
        cdb_mark = cdb_log.size();
        rd_mark  = rd_log.size();
        sq[2]    = '{1'b1, 1'b1, a ^ 16'h0004, SIZE_WORD, data_t'($urandom)};
        issue_loads(1, r, sq_idx_t'(3));
        send_addr(r, a);
        expect_silent(10);
        sq_head = sq_idx_t'(3);
        wait_cdb(cdb_mark, 1);
        exp_req = '{a, SIZE_WORD};
        compare_rd_req("rd_req", rd_log[rd_mark], exp_req);
        compare_cdb("cdb", cdb_log[cdb_mark], cache_result(r));
        clear_store_queue();
    endtask

    task automatic test_credits();
        rob_idx_t base;
        int       mark;
        int       pairs;
        int       seen [ROB_DEPTH];
        base  = rob_idx_t'($urandom);
        mark  = cdb_log.size();
        pairs = 0;
        foreach (seen[k]) begin
            seen[k] = 0;
        end
        while (credits_left() >= ISSUE_WAYS) begin
            issue_loads(ISSUE_WAYS, base + rob_idx_t'(2 * pairs), sq_head);
            pairs++;
        end
        compare_count("loads issued", 2 * pairs, LQ_DEPTH);
        compare_count("credits after issue", credits_left(), 0);
        for (int k = 0; k < LQ_DEPTH; k++) begin
            send_addr(base + rob_idx_t'(k), addr_t'($urandom));
        end
        wait_cdb(mark, LQ_DEPTH);
        expect_silent(5);
        compare_count("CDB beats", cdb_log.size() - mark, LQ_DEPTH);
        for (int k = mark; k < cdb_log.size(); k++) begin
            seen[cdb_log[k].rob_idx]++;
            compare_cdb("cdb", cdb_log[k], cache_result(cdb_log[k].rob_idx));
        end
        for (int k = 0; k < LQ_DEPTH; k++) begin
            compare_count($sformatf("CDB beats for rob %0d", base + rob_idx_t'(k)),
                          seen[base + rob_idx_t'(k)], 1);
        end
        compare_count("credits after drain", credits_left(), LQ_DEPTH);
    endtask

    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        fail_run("watchdog expired before the tests finished");
    end

    initial begin
        void'($urandom(67));
        clock       = 1'b0;
        rst         = 1'b1;
        except      = 1'b0;
        ld_en       = '0;
        sq_head     = '0;
        miss_target = 0;
        issued      = 0;
        flushed     = '0;
        foreach (ld_issue[w]) begin
            ld_issue[w] = '0;
        end
        foreach (alu[w]) begin
            alu[w] = '0;
        end
        foreach (sq[k]) begin
            sq[k] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clock);
        #DRIVE_DELAY;
        rst = 1'b0;

        test_reset_and_flush();
        test_forwarding();
        test_cache_miss();
        test_store_wait();
        test_credits();

        $display("TEST OK");
        $finish;
    end

endmodule

// ==== load_queue.f ====
design/lq_pkg.sv
design/lq_alloc.sv
design/lq_rr_arbiter.sv
design/lq_store_check.sv
design/lq_entries.sv
design/load_queue.sv
sim/load_queue_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the load queue testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -sv \
    --top-module load_queue_tb -Mdir "$BUILD_DIR" -o load_queue_sim \
    -f load_queue.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/load_queue_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "TEST OK" "$LOG"; then
    exit 0
else
    echo "pass message not found in $LOG"
    exit 1
fi
